// File: files.f
hw/core_pkg.sv
hw/priv_pkg.sv
hw/ctrl_if.sv
hw/inst_fetch.sv
hw/decoder.sv
hw/register_file.sv
hw/execute_unit.sv
hw/trap_csr.sv
hw/processor_core.sv
test/tb_mem.sv
test/tb_processor_core.sv

// File: hw/core_pkg.sv
package core_pkg;

  localparam int XLEN = 32;
  localparam int INST_WIDTH = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_ADDR_WIDTH = $clog2(NUM_REGS);

  localparam logic [XLEN-1:0] PC_RESET_VECTOR = '0;

  // RV32I major opcodes used by this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    BU_NONE,
    BU_EQ,
    BU_NE,
    BU_LT,
    BU_GE
  } bu_op_t;

  typedef enum logic {ALU_A_RS1, ALU_A_PC} alu_a_sel_t;
  typedef enum logic {ALU_B_RS2, ALU_B_IMM} alu_b_sel_t;

  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM, WB_CSR} wb_sel_t;

endpackage

// File: hw/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if;

  import core_pkg::*;

  alu_op_t alu_op;
  alu_a_sel_t a_sel;
  alu_b_sel_t b_sel;
  bu_op_t bu_op;
  wb_sel_t wb_sel;
  logic [XLEN-1:0] imm;
  // Forces the branch taken for JAL and JALR
  logic jump;

  modport decoder (
    output alu_op, a_sel, b_sel, bu_op, wb_sel, imm, jump
  );

  modport exec (
    input alu_op, a_sel, b_sel, bu_op, wb_sel, imm, jump
  );

endinterface

// File: hw/decoder.sv
`timescale 1ns/1ns

module decoder (
  ctrl_if.decoder                             ctrl,
  input  logic [core_pkg::INST_WIDTH-1:0]     i_inst,
  output logic                                o_rf_we,
  output logic [core_pkg::REG_ADDR_WIDTH-1:0] o_rd_addr,
  output logic [core_pkg::REG_ADDR_WIDTH-1:0] o_rs1_addr,
  output logic [core_pkg::REG_ADDR_WIDTH-1:0] o_rs2_addr,
  output logic                                o_dmem_we,
  output priv_pkg::csr_op_t                   o_csr_op,
  output priv_pkg::csr_addr_t                 o_csr_addr,
  output logic                                o_t_illegal,
  output logic                                o_t_ecall,
  output logic                                o_mret
);

  import core_pkg::*;
  import priv_pkg::*;

  opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_reg;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  alu_op_t arith_op;
  logic arith_ok;
  logic rf_we;
  logic dmem_we;
  csr_op_t csr_op;
  logic illegal;
  logic ecall;
  logic mret;
  logic trap;

  assign opcode = opcode_t'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign is_reg = (opcode == OP);

  assign o_rd_addr = i_inst[11:7];
  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];
  assign o_csr_addr = csr_addr_t'(i_inst[31:20]);

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // Shared funct decode for OP and OP_IMM
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000: arith_op = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b100: arith_op = ALU_XOR;
      3'b101: arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110: arith_op = ALU_OR;
      3'b111: arith_op = ALU_AND;
      default: begin
        arith_op = ALU_ADD;
        arith_ok = 1'b0;
      end
    endcase
    // funct7 is zero except for SUB, SRA and SRAI
    if (is_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
      if (funct7 != 7'b0 &&
          !(funct7 == 7'b0100000 && (funct3 == 3'b101 || (is_reg && funct3 == 3'b000)))) begin
        arith_ok = 1'b0;
      end
    end
  end

  always_comb begin
    ctrl.alu_op = ALU_ADD;
    ctrl.a_sel = ALU_A_RS1;
    ctrl.b_sel = ALU_B_IMM;
    ctrl.bu_op = BU_NONE;
    ctrl.wb_sel = WB_ALU;
    ctrl.imm = imm_i;
    ctrl.jump = 1'b0;
    rf_we = 1'b0;
    dmem_we = 1'b0;
    csr_op = CSR_NONE;
    illegal = 1'b0;
    ecall = 1'b0;
    mret = 1'b0;

    case (opcode)
      OP, OP_IMM: begin
        rf_we = 1'b1;
        ctrl.alu_op = arith_op;
        ctrl.b_sel = is_reg ? ALU_B_RS2 : ALU_B_IMM;
        illegal = !arith_ok;
      end
      LUI: begin
        rf_we = 1'b1;
        ctrl.alu_op = ALU_PASS_B;
        ctrl.imm = imm_u;
      end
      AUIPC: begin
        rf_we = 1'b1;
        ctrl.a_sel = ALU_A_PC;
        ctrl.imm = imm_u;
      end
      BRANCH: begin
        ctrl.a_sel = ALU_A_PC;
        ctrl.imm = imm_b;
        case (funct3)
          3'b000: ctrl.bu_op = BU_EQ;
          3'b001: ctrl.bu_op = BU_NE;
          3'b100: ctrl.bu_op = BU_LT;
          3'b101: ctrl.bu_op = BU_GE;
          default: illegal = 1'b1;
        endcase
      end
      JAL: begin
        rf_we = 1'b1;
        ctrl.a_sel = ALU_A_PC;
        ctrl.imm = imm_j;
        ctrl.wb_sel = WB_PC4;
        ctrl.jump = 1'b1;
      end
      JALR: begin
        rf_we = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.jump = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      LOAD: begin
        rf_we = 1'b1;
        ctrl.wb_sel = WB_MEM;
        illegal = (funct3 != 3'b010);
      end
      STORE: begin
        dmem_we = 1'b1;
        ctrl.imm = imm_s;
        illegal = (funct3 != 3'b010);
      end
      SYSTEM: begin
        ctrl.wb_sel = WB_CSR;
        case (funct3)
          3'b000: begin
            ecall = (i_inst == INST_ECALL);
            mret = (i_inst == INST_MRET);
            illegal = !(ecall || mret);
          end
          3'b001: begin
            rf_we = 1'b1;
            csr_op = CSR_RW;
          end
          3'b010: begin
            rf_we = 1'b1;
            csr_op = CSR_RS;
          end
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // A trapping instruction leaves no architectural side effects
  assign trap = illegal | ecall;
  assign o_rf_we = rf_we & ~trap;
  assign o_dmem_we = dmem_we & ~trap;
  assign o_csr_op = trap ? CSR_NONE : csr_op;
  assign o_t_illegal = illegal;
  assign o_t_ecall = ecall;
  assign o_mret = mret;

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
  ctrl_if.exec                      ctrl,
  input  logic [core_pkg::XLEN-1:0] i_rs1,
  input  logic [core_pkg::XLEN-1:0] i_rs2,
  input  logic [core_pkg::XLEN-1:0] i_pc,
  input  logic [core_pkg::XLEN-1:0] i_pc_4,
  input  logic [core_pkg::XLEN-1:0] i_mem_rdata,
  input  logic [core_pkg::XLEN-1:0] i_csr_rdata,
  output logic [core_pkg::XLEN-1:0] o_result,
  output logic [core_pkg::XLEN-1:0] o_wb_data,
  output logic                      o_take_branch
);

  import core_pkg::*;

  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [4:0] shamt;
  logic cond;

  assign alu_a = (ctrl.a_sel == ALU_A_PC) ? i_pc : i_rs1;
  assign alu_b = (ctrl.b_sel == ALU_B_IMM) ? ctrl.imm : i_rs2;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB:    o_result = alu_a - alu_b;
      ALU_AND:    o_result = alu_a & alu_b;
      ALU_OR:     o_result = alu_a | alu_b;
      ALU_XOR:    o_result = alu_a ^ alu_b;
      ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLL:    o_result = alu_a << shamt;
      ALU_SRL:    o_result = alu_a >> shamt;
      ALU_SRA:    o_result = $unsigned($signed(alu_a) >>> shamt);
      ALU_PASS_B: o_result = alu_b;
      default:    o_result = alu_a + alu_b;
    endcase
  end

  // Branch compare always works on rs1 and rs2
  always_comb begin
    case (ctrl.bu_op)
      BU_EQ:   cond = (i_rs1 == i_rs2);
      BU_NE:   cond = (i_rs1 != i_rs2);
      BU_LT:   cond = ($signed(i_rs1) < $signed(i_rs2));
      BU_GE:   cond = ($signed(i_rs1) >= $signed(i_rs2));
      default: cond = 1'b0;
    endcase
  end

  assign o_take_branch = ctrl.jump | cond;

  always_comb begin
    case (ctrl.wb_sel)
      WB_PC4:  o_wb_data = i_pc_4;
      WB_MEM:  o_wb_data = i_mem_rdata;
      WB_CSR:  o_wb_data = i_csr_rdata;
      default: o_wb_data = o_result;
    endcase
  end

endmodule

// File: hw/inst_fetch.sv
`timescale 1ns/1ns

module inst_fetch (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_take_branch,
  input  logic [core_pkg::XLEN-1:0] i_branch_target,
  input  logic                      i_redirect,
  input  logic [core_pkg::XLEN-1:0] i_redirect_pc,
  output logic [core_pkg::XLEN-1:0] o_pc,
  output logic [core_pkg::XLEN-1:0] o_pc_4
);

  import core_pkg::*;

  logic [XLEN-1:0] pc_next;

  assign o_pc_4 = o_pc + XLEN'(4);

  // Trap and MRET redirects win over branches
  always_comb begin
    if (i_redirect) begin
      pc_next = i_redirect_pc;
    end else if (i_take_branch) begin
      pc_next = {i_branch_target[XLEN-1:1], 1'b0};
    end else begin
      pc_next = o_pc_4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_pc <= PC_RESET_VECTOR;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

// File: hw/priv_pkg.sv
package priv_pkg;

  localparam int MXLEN = 32;
  localparam int CSR_ADDR_WIDTH = 12;

  typedef enum logic [CSR_ADDR_WIDTH-1:0] {
    CSR_MTVEC  = 12'h305,
    CSR_MEPC   = 12'h341,
    CSR_MCAUSE = 12'h342
  } csr_addr_t;

  typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS} csr_op_t;

  typedef enum logic [MXLEN-1:0] {
    CAUSE_ILLEGAL_INST = 32'd2,
    CAUSE_ECALL_M      = 32'd11
  } trap_cause_t;

  localparam logic [MXLEN-1:0] MTVEC_RESET = 32'h0000_0100;

  // Full encodings of the two SYSTEM instructions without operands
  localparam logic [31:0] INST_ECALL = 32'h0000_0073;
  localparam logic [31:0] INST_MRET = 32'h3020_0073;

endpackage

// File: hw/processor_core.sv
`timescale 1ns/1ns

module processor_core (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic [core_pkg::INST_WIDTH-1:0] i_imem_data,
  input  logic [core_pkg::XLEN-1:0]       i_dmem_rdata,
  output logic [core_pkg::XLEN-1:0]       o_imem_addr,
  output logic [core_pkg::XLEN-1:0]       o_dmem_addr,
  output logic                            o_dmem_we,
  output logic [core_pkg::XLEN-1:0]       o_dmem_wdata
);

  import core_pkg::*;
  import priv_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_4;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] wb_data;
  logic take_branch;

  logic rf_we;
  logic dmem_we;
  logic [REG_ADDR_WIDTH-1:0] rd_addr;
  logic [REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [REG_ADDR_WIDTH-1:0] rs2_addr;

  csr_op_t csr_op;
  csr_addr_t csr_addr;
  logic [MXLEN-1:0] csr_rdata;
  logic t_illegal;
  logic t_ecall;
  logic mret;
  logic redirect;
  logic [MXLEN-1:0] redirect_pc;

  assign o_imem_addr = pc;
  assign o_dmem_addr = result;
  assign o_dmem_wdata = rs2;

  // Stores held off while reset is asserted
  assign o_dmem_we = dmem_we & i_rst_n;

  ctrl_if ctrl();

  inst_fetch ifu (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_take_branch(take_branch),
    .i_branch_target(result),
    .i_redirect(redirect),
    .i_redirect_pc(redirect_pc),
    .o_pc(pc),
    .o_pc_4(pc_4)
  );

  decoder dec (
    .ctrl(ctrl.decoder),
    .i_inst(i_imem_data),
    .o_rf_we(rf_we),
    .o_rd_addr(rd_addr),
    .o_rs1_addr(rs1_addr),
    .o_rs2_addr(rs2_addr),
    .o_dmem_we(dmem_we),
    .o_csr_op(csr_op),
    .o_csr_addr(csr_addr),
    .o_t_illegal(t_illegal),
    .o_t_ecall(t_ecall),
    .o_mret(mret)
  );

  register_file rf (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_we(rf_we),
    .i_waddr(rd_addr),
    .i_wdata(wb_data),
    .i_raddr1(rs1_addr),
    .i_raddr2(rs2_addr),
    .o_rdata1(rs1),
    .o_rdata2(rs2)
  );

  execute_unit exu (
    .ctrl(ctrl.exec),
    .i_rs1(rs1),
    .i_rs2(rs2),
    .i_pc(pc),
    .i_pc_4(pc_4),
    .i_mem_rdata(i_dmem_rdata),
    .i_csr_rdata(csr_rdata),
    .o_result(result),
    .o_wb_data(wb_data),
    .o_take_branch(take_branch)
  );

  // CSR write data is always rs1
  trap_csr csr (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_pc(pc),
    .i_csr_op(csr_op),
    .i_csr_addr(csr_addr),
    .i_csr_wdata(rs1),
    .i_t_illegal(t_illegal),
    .i_t_ecall(t_ecall),
    .i_mret(mret),
    .o_csr_rdata(csr_rdata),
    .o_redirect(redirect),
    .o_redirect_pc(redirect_pc)
  );

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ns

module register_file (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_we,
  input  logic [core_pkg::REG_ADDR_WIDTH-1:0] i_waddr,
  input  logic [core_pkg::XLEN-1:0]           i_wdata,
  input  logic [core_pkg::REG_ADDR_WIDTH-1:0] i_raddr1,
  input  logic [core_pkg::REG_ADDR_WIDTH-1:0] i_raddr2,
  output logic [core_pkg::XLEN-1:0]           o_rdata1,
  output logic [core_pkg::XLEN-1:0]           o_rdata2
);

  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 always reads zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: hw/trap_csr.sv
`timescale 1ns/1ns

module trap_csr (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [priv_pkg::MXLEN-1:0] i_pc,
  input  priv_pkg::csr_op_t          i_csr_op,
  input  priv_pkg::csr_addr_t        i_csr_addr,
  input  logic [priv_pkg::MXLEN-1:0] i_csr_wdata,
  input  logic                       i_t_illegal,
  input  logic                       i_t_ecall,
  input  logic                       i_mret,
  output logic [priv_pkg::MXLEN-1:0] o_csr_rdata,
  output logic                       o_redirect,
  output logic [priv_pkg::MXLEN-1:0] o_redirect_pc
);

  import priv_pkg::*;

  logic [MXLEN-1:0] mtvec;
  logic [MXLEN-1:0] mepc;
  logic [MXLEN-1:0] mcause;
  logic [MXLEN-1:0] csr_new;
  logic trap;

  assign trap = i_t_ecall | i_t_illegal;

  always_comb begin
    case (i_csr_addr)
      CSR_MTVEC:  o_csr_rdata = mtvec;
      CSR_MEPC:   o_csr_rdata = mepc;
      CSR_MCAUSE: o_csr_rdata = mcause;
      default:    o_csr_rdata = '0;
    endcase
  end

  // CSRRS ORs into the old value
  assign csr_new = (i_csr_op == CSR_RS) ? (o_csr_rdata | i_csr_wdata) : i_csr_wdata;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mtvec <= MTVEC_RESET;
      mepc <= '0;
      mcause <= '0;
    end else if (trap) begin
      mepc <= i_pc;
      mcause <= i_t_ecall ? CAUSE_ECALL_M : CAUSE_ILLEGAL_INST;
    end else if (i_csr_op != CSR_NONE) begin
      case (i_csr_addr)
        CSR_MTVEC:  mtvec <= csr_new;
        CSR_MEPC:   mepc <= csr_new;
        CSR_MCAUSE: mcause <= csr_new;
        default:    ;
      endcase
    end
  end

  assign o_redirect = trap | i_mret;
  assign o_redirect_pc = trap ? mtvec : mepc;

endmodule

// File: test/tb_mem.sv
`timescale 1ns/1ns

module tb_mem (
  input  logic        i_clk,
  input  logic [31:0] i_imem_addr,
  output logic [31:0] o_imem_data,
  input  logic [31:0] i_dmem_addr,
  input  logic        i_dmem_we,
  input  logic [31:0] i_dmem_wdata,
  output logic [31:0] o_dmem_rdata
);

  logic [31:0] rom [1024];
  logic [31:0] ram [512];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];

  // Both read ports are combinational
  assign o_imem_data = rom[i_imem_addr[11:2]];
  assign o_dmem_rdata = ram[i_dmem_addr[10:2]];

  // Stores taken mid-cycle, core outputs settled by then
  always @(negedge i_clk) begin
    if (i_dmem_we === 1'b1) begin
      ram[i_dmem_addr[10:2]] = i_dmem_wdata;
      log_addr.push_back(i_dmem_addr);
      log_data.push_back(i_dmem_wdata);
    end
  end

  task automatic write_inst(input logic [31:0] addr, input logic [31:0] word);
    rom[addr[11:2]] = word;
  endtask

  // Oldest logged store, if any
  task automatic pop_store(output logic found, output logic [31:0] addr,
                           output logic [31:0] data);
    found = (log_addr.size() != 0);
    if (found) begin
      addr = log_addr.pop_front();
      data = log_data.pop_front();
    end
  endtask

endmodule

// File: test/tb_processor_core.sv
`timescale 1ns/1ns

module tb_processor_core;

  localparam int NUM_TESTS = 6;
  localparam int STORE_TIMEOUT = 200;
  localparam logic [31:0] MAIN_BASE = 32'h0000_0200;

  logic clk = 1'b0;
  logic rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_wdata;
  logic dmem_we;

  int seed;
  int errors;
  int checks;
  int passed;
  int test_err [NUM_TESTS];
  int last_idx [NUM_TESTS];
  string test_name [NUM_TESTS];
  logic [31:0] pc;
  logic [31:0] data_ptr;
  logic [31:0] mcause_model;
  logic [31:0] mtvec_model;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int exp_test [$];

  processor_core i_processor_core (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_imem_data(imem_data),
    .i_dmem_rdata(dmem_rdata),
    .o_imem_addr(imem_addr),
    .o_dmem_addr(dmem_addr),
    .o_dmem_we(dmem_we),
    .o_dmem_wdata(dmem_wdata)
  );

  tb_mem mem (
    .i_clk(clk),
    .i_imem_addr(imem_addr),
    .o_imem_data(imem_data),
    .i_dmem_addr(dmem_addr),
    .i_dmem_we(dmem_we),
    .i_dmem_wdata(dmem_wdata),
    .o_dmem_rdata(dmem_rdata)
  );

  always #50 clk = ~clk;

  // No store may leave the core while reset is held
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (dmem_we === 1'b0) else begin
        $display("Fail at %0t ns: o_dmem_we = %b, expected 0 during reset", $time, dmem_we);
        errors++;
      end
      // PC sits at the reset vector
      assert (imem_addr === 32'h0) else begin
        $display("Fail at %0t ns: o_imem_addr = 0x%08h, expected 0x00000000 during reset",
                 $time, imem_addr);
        errors++;
      end
    end
  end

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // SW only
  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
  endfunction

  // funct7 and funct3 of ADD SUB AND OR XOR SLT SLL SRL SRA
  function automatic logic [9:0] alu_funct(input int k);
    case (k)
      1: return {7'h20, 3'b000};
      2: return {7'h00, 3'b111};
      3: return {7'h00, 3'b110};
      4: return {7'h00, 3'b100};
      5: return {7'h00, 3'b010};
      6: return {7'h00, 3'b001};
      7: return {7'h00, 3'b101};
      8: return {7'h20, 3'b101};
      default: return {7'h00, 3'b000};
    endcase
  endfunction

  function automatic logic [31:0] expected_alu(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [4:0] s;
    s = b[4:0];
    case (k)
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6: return a << s;
      7: return a >> s;
      8: return (a >> s) | (a[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0);
      default: return a + b;
    endcase
  endfunction

  // BEQ BNE BLT BGE
  function automatic logic [2:0] branch_funct3(input int k);
    case (k)
      1: return 3'b001;
      2: return 3'b100;
      3: return 3'b101;
      default: return 3'b000;
    endcase
  endfunction

  function automatic logic branch_taken(input int k, input logic [31:0] a,
                                       input logic [31:0] b);
    case (k)
      1: return a != b;
      2: return $signed(a) < $signed(b);
      3: return $signed(a) >= $signed(b);
      default: return a == b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    mem.write_inst(pc, word);
    pc += 4;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] value, input int t);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
    exp_test.push_back(t);
  endtask

  task automatic store_reg(input logic [4:0] rs, input logic [31:0] value, input int t);
    emit(stype(data_ptr[11:0], rs, 5'd0));
    expect_store(data_ptr, value, t);
    data_ptr += 4;
  endtask

  // LUI and ADDI pair
  task automatic load_imm(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit({upper[31:12], rd, 7'h37});
    emit(itype(value[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  // Handler stores mcause and mepc and returns past the trap
  task automatic build_handler(input logic [31:0] base, input logic [31:0] slot);
    pc = base;
    emit(itype(12'h342, 5'd0, 3'b010, 5'd10, 7'h73));
    emit(stype(slot[11:0], 5'd10, 5'd0));
    emit(itype(12'h341, 5'd0, 3'b010, 5'd11, 7'h73));
    emit(stype(slot[11:0] + 12'd4, 5'd11, 5'd0));
    emit(itype(12'd4, 5'd11, 3'b000, 5'd11, 7'h13));
    emit(itype(12'h341, 5'd11, 3'b001, 5'd0, 7'h73));
    emit(32'h3020_0073);
  endtask

  task automatic trap_case(input logic [31:0] word, input logic [31:0] cause, input int t);
    logic [31:0] slot;
    logic [31:0] trap_pc;
    slot = (mtvec_model == 32'h100) ? 32'h700 : 32'h708;
    trap_pc = pc;
    emit(word);
    mcause_model = cause;
    expect_store(slot, cause, t);
    expect_store(slot + 4, trap_pc, t);
    // Instruction after the trap stores its own address
    emit({20'h0, 5'd9, 7'h17});
    store_reg(5'd9, trap_pc + 4, t);
  endtask

  // Marker 2 on the taken path and 1 on the other
  task automatic branch_case(input int k, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] va, input logic [31:0] vb);
    emit(btype(13'd12, rs2, rs1, branch_funct3(k)));
    emit(itype(12'd1, 5'd0, 3'b000, 5'd5, 7'h13));
    emit(jtype(21'd8, 5'd0));
    emit(itype(12'd2, 5'd0, 3'b000, 5'd5, 7'h13));
    store_reg(5'd5, branch_taken(k, va, vb) ? 32'd2 : 32'd1, 2);
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [31:0] p;
    logic [9:0] fn;
    pc = 32'h0;
    // Reset vector holds a store that must stay quiet during reset
    emit(stype(12'h3FC, 5'd0, 5'd0));
    expect_store(32'h3FC, 32'h0, 1);
    emit(jtype(MAIN_BASE[20:0] - 21'd4, 5'd0));
    build_handler(32'h100, 32'h700);
    build_handler(32'h180, 32'h708);
    pc = MAIN_BASE;
    data_ptr = 32'h400;
    mtvec_model = 32'h100;
    mcause_model = 32'h0;
    a = 32'h0;
    b = 32'h0;
    for (int r = 0; r < 2; r++) begin
      a = $random(seed);
      b = $random(seed);
      // Negative rs1 in the first round for SRA
      if (r == 0) a[31] = 1'b1;
      load_imm(5'd1, a);
      load_imm(5'd2, b);
      for (int k = 0; k < 9; k++) begin
        fn = alu_funct(k);
        emit({fn[9:3], 5'd2, 5'd1, fn[2:0], 5'd3, 7'h33});
        store_reg(5'd3, expected_alu(k, a, b), 0);
      end
      v = $random(seed);
      emit(itype(v[11:0], 5'd1, 3'b000, 5'd3, 7'h13));
      store_reg(5'd3, a + {{20{v[11]}}, v[11:0]}, 0);
    end
    v = $random(seed);
    p = pc;
    emit({v[19:0], 5'd3, 7'h17});
    store_reg(5'd3, p + {v[19:0], 12'h0}, 0);
    emit({v[31:12], 5'd0, 7'h37});
    emit(itype(12'd7, 5'd1, 3'b000, 5'd0, 7'h13));
    store_reg(5'd0, 32'h0, 1);
    p = data_ptr;
    store_reg(5'd1, a, 1);
    emit(itype(p[11:0], 5'd0, 3'b010, 5'd4, 7'h03));
    store_reg(5'd4, a, 1);
    for (int k = 0; k < 4; k++) begin
      branch_case(k, 5'd1, 5'd2, a, b);
      branch_case(k, 5'd2, 5'd1, b, a);
      branch_case(k, 5'd1, 5'd1, a, a);
    end
    // Skipped slots hold a stray store that must never show up
    p = pc;
    emit(jtype(21'd8, 5'd6));
    emit(stype(12'h7F0, 5'd0, 5'd0));
    store_reg(5'd6, p + 4, 2);
    p = pc;
    emit({20'h0, 5'd7, 7'h17});
    emit(itype(12'd12, 5'd7, 3'b000, 5'd8, 7'h67));
    emit(stype(12'h7F0, 5'd0, 5'd0));
    store_reg(5'd8, p + 8, 2);
    trap_case(32'h0000_0073, 32'd11, 3);
    trap_case(32'h0000_0000, 32'd2, 4);
    // SB is outside the subset and must not reach memory
    trap_case({7'h3F, 5'd0, 5'd0, 3'b000, 5'h10, 7'h23}, 32'd2, 4);
    emit(itype(12'h05A, 5'd0, 3'b000, 5'd5, 7'h13));
    // MUL is outside the subset so x5 keeps its value
    trap_case({7'h01, 5'd7, 5'd6, 3'b000, 5'd5, 7'h33}, 32'd2, 4);
    store_reg(5'd5, 32'h5A, 4);
    emit(itype(12'h180, 5'd0, 3'b000, 5'd12, 7'h13));
    emit(itype(12'h305, 5'd12, 3'b001, 5'd13, 7'h73));
    store_reg(5'd13, mtvec_model, 5);
    mtvec_model = 32'h180;
    trap_case(32'h0000_0073, 32'd11, 5);
    emit(itype(12'h030, 5'd0, 3'b000, 5'd12, 7'h13));
    emit(itype(12'h342, 5'd12, 3'b010, 5'd13, 7'h73));
    emit(itype(12'h342, 5'd0, 3'b010, 5'd14, 7'h73));
    store_reg(5'd13, mcause_model, 5);
    mcause_model = mcause_model | 32'h30;
    store_reg(5'd14, mcause_model, 5);
    emit(jtype(21'd0, 5'd0));
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int t);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      errors++;
      test_err[t]++;
    end
  endtask

  task automatic wait_store(output logic found, output logic [31:0] addr,
                            output logic [31:0] data);
    int cycles;
    cycles = 0;
    mem.pop_store(found, addr, data);
    while (!found && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      mem.pop_store(found, addr, data);
    end
  endtask

  initial begin
    logic found;
    logic [31:0] got_addr;
    logic [31:0] got_data;
    int t;
    seed = 48224;
    errors = 0;
    checks = 0;
    passed = 0;
    rst_n = 1'b0;
    test_name[0] = "arithmetic and logic";
    test_name[1] = "x0 and writeback";
    test_name[2] = "branches and jumps";
    test_name[3] = "ECALL trap";
    test_name[4] = "illegal instruction";
    test_name[5] = "CSR access";
    for (int n = 0; n < NUM_TESTS; n++) begin
      test_err[n] = 0;
      last_idx[n] = -1;
    end
    build_program();
    // A test finishes with its last expected store
    for (int i = 0; i < exp_test.size(); i++) begin
      last_idx[exp_test[i]] = i;
    end
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < exp_addr.size(); i++) begin
      t = exp_test[i];
      wait_store(found, got_addr, got_data);
      if (!found) begin
        $display("Timeout: no store seen within %0d cycles in test %0d", STORE_TIMEOUT, t + 1);
        errors++;
        break;
      end
      compare_word("o_dmem_addr", got_addr, exp_addr[i], t);
      compare_word("o_dmem_wdata", got_data, exp_data[i], t);
      if (i == last_idx[t]) begin
        $display("Test %0d %s: %s", t + 1, test_name[t], (test_err[t] == 0) ? "ok" : "bad");
        if (test_err[t] == 0) passed++;
      end
    end
    $display("Tests passed %0d of %0d, checks %0d, errors %0d", passed, NUM_TESTS, checks,
             errors);
    if (errors == 0 && passed == NUM_TESTS) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
